//--- common/pov_pkg.sv
package pov_pkg;

    // Display geometry, scaled down from the full wheel
    // LEDs stacked in one driver column
    localparam int leds_per_driver = 8;
    // Facing driver pairs side by side in one row
    localparam int pairs_per_row = 3;
    localparam int driver_rows = 2;
    // Both halves of every facing pair are counted here
    localparam int num_drivers = 2 * pairs_per_row * driver_rows;
    // Columns that each driver multiplexes over one slice
    localparam int mux_columns = 4;
    // Slices held in RAM before the fill pointer wraps
    localparam int slices_in_ram = 4;

    // Pixels needed for one column across all driver pairs
    localparam int buff_size = driver_rows * leds_per_driver * pairs_per_row;
    // Words in one slice of the image
    localparam int image_size = buff_size * mux_columns;
    localparam int ram_words = image_size * slices_in_ram;
    localparam int ram_addr_w = $clog2(ram_words);

    // Nine planes per column, the first five carry colour and the rest are dark
    localparam int poker_planes = 9;
    localparam int color_planes = 5;

    // RGB565 pixel as the host stores it
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixel_t;

    // Host request on the Wishbone classic port
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [ram_addr_w-1:0] adr;
        pixel_t dat;
    } wb_req_t;

    // Slave response, read data is valid together with ack
    typedef struct packed {
        logic ack;
        pixel_t dat;
    } wb_rsp_t;

    // One bit per colour channel for a single LED in the current plane
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } led_bits_t;

    // One plane for every LED of every driver, 288 bits in total
    typedef led_bits_t [num_drivers-1:0][leds_per_driver-1:0] driver_plane_t;

    // Column sequencer states
    typedef enum logic [1:0] {
        seq_idle,
        seq_prime,
        seq_show,
        seq_wait_fill
    } seq_state_t;

endpackage

//--- framebuffer/column_sequencer.sv
`timescale 1ns/1ps

module column_sequencer (
    input  logic clk,
    input  logic nrst,

    input  logic stream_enable,
    // A plane is taken only while the driver is ready
    input  logic driver_ready,
    input  logic fill_done,

    output logic swap,
    output logic rewind,
    output logic [3:0] plane_num,
    output logic plane_valid
);

    pov_pkg::seq_state_t state;

    logic accept;
    logic fill_ready;

    // The buffers flip at the end of a swap cycle, so no plane goes out then
    assign plane_valid = (state == pov_pkg::seq_show) && !swap;
    assign accept = plane_valid && driver_ready;

    // fill_done still shows the previous fill during the swap cycle itself
    assign fill_ready = fill_done && !swap;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= pov_pkg::seq_idle;
            swap <= 1'b0;
            rewind <= 1'b0;
            plane_num <= 4'(pov_pkg::poker_planes - 1);
        end else begin
            swap <= 1'b0;
            rewind <= 1'b0;
            if (!stream_enable) begin
                // Stopping the stream restarts the image at slice 0, column 0
                if (state != pov_pkg::seq_idle) begin
                    rewind <= 1'b1;
                end
                state <= pov_pkg::seq_idle;
                plane_num <= 4'(pov_pkg::poker_planes - 1);
            end else begin
                case (state)
                    pov_pkg::seq_idle: begin
                        // First swap only starts the fill of column 0
                        swap <= 1'b1;
                        state <= pov_pkg::seq_prime;
                    end
                    pov_pkg::seq_prime: begin
                        if (fill_ready) begin
                            swap <= 1'b1;
                            state <= pov_pkg::seq_show;
                            plane_num <= 4'(pov_pkg::poker_planes - 1);
                        end
                    end
                    pov_pkg::seq_show: begin
                        if (accept) begin
                            if (plane_num != 4'd0) begin
                                plane_num <= plane_num - 4'd1;
                            end else if (fill_ready) begin
                                // The next column is ready so the stream goes straight on
                                swap <= 1'b1;
                                plane_num <= 4'(pov_pkg::poker_planes - 1);
                            end else begin
                                state <= pov_pkg::seq_wait_fill;
                            end
                        end
                    end
                    pov_pkg::seq_wait_fill: begin
                        if (fill_ready) begin
                            swap <= 1'b1;
                            state <= pov_pkg::seq_show;
                            plane_num <= 4'(pov_pkg::poker_planes - 1);
                        end
                    end
                    default: begin
                        state <= pov_pkg::seq_idle;
                    end
                endcase
            end
        end
    end

endmodule

//--- framebuffer/framebuffer.sv
`timescale 1ns/1ps

module framebuffer (
    input  logic clk,
    input  logic nrst,

    // Buffer flip request from the column sequencer
    input  logic swap,
    // Return the fill pointer to slice 0, column 0
    input  logic rewind,
    // Plane shown to the drivers, 8 down to 0
    input  logic [3:0] plane_num,

    // Pixel RAM read port
    output logic [pov_pkg::ram_addr_w-1:0] rd_addr,
    input  pov_pkg::pixel_t rd_data,

    output logic fill_done,
    output pov_pkg::driver_plane_t plane
);

    typedef logic [pov_pkg::ram_addr_w-1:0] addr_t;
    typedef logic [$clog2(pov_pkg::buff_size)-1:0] idx_t;
    typedef logic [$clog2(pov_pkg::slices_in_ram)-1:0] slice_t;
    typedef logic [$clog2(pov_pkg::mux_columns)-1:0] col_t;

    // Two column buffers, one is shown while the other is filled from RAM
    pov_pkg::pixel_t buf_a [pov_pkg::buff_size];
    pov_pkg::pixel_t buf_b [pov_pkg::buff_size];

    // High when buf_b is the shown buffer, so buf_a takes the fill
    logic show_b;

    // Column fill engine
    logic fill_active;
    idx_t fill_idx;
    addr_t fill_base;
    // Slice and column of the next column to fill
    slice_t slice_ptr;
    col_t col_ptr;

    // Write side trails the address by the RAM read latency
    logic wr_en;
    idx_t wr_idx;

    // Bit of the colour channels picked by the current plane
    logic [2:0] color_bit;
    logic color_plane;

    // Buffer index k of the column lives at base plus mux_columns times k,
    // since the next pixel of the same column is one multiplex group further
    assign rd_addr = fill_base + addr_t'(fill_idx) * addr_t'(pov_pkg::mux_columns);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            show_b <= 1'b0;
            fill_active <= 1'b0;
            fill_done <= 1'b0;
            fill_idx <= '0;
            fill_base <= '0;
            slice_ptr <= '0;
            col_ptr <= '0;
            wr_en <= 1'b0;
            wr_idx <= '0;
        end else begin
            wr_en <= fill_active;
            wr_idx <= fill_idx;
            if (swap) begin
                // The buffer just filled is shown and the other one is refilled
                show_b <= !show_b;
                fill_active <= 1'b1;
                fill_done <= 1'b0;
                fill_idx <= '0;
                fill_base <= addr_t'(slice_ptr) * addr_t'(pov_pkg::image_size)
                    + addr_t'(col_ptr);
                // Columns step first, then the slice, which wraps at the end of RAM
                if (col_ptr == col_t'(pov_pkg::mux_columns - 1)) begin
                    col_ptr <= '0;
                    if (slice_ptr == slice_t'(pov_pkg::slices_in_ram - 1)) begin
                        slice_ptr <= '0;
                    end else begin
                        slice_ptr <= slice_ptr + 1'b1;
                    end
                end else begin
                    col_ptr <= col_ptr + 1'b1;
                end
            end else if (fill_active) begin
                fill_idx <= fill_idx + 1'b1;
                // The last pixel is still in flight, it lands before any swap
                // can follow this flag
                if (fill_idx == idx_t'(pov_pkg::buff_size - 1)) begin
                    fill_active <= 1'b0;
                    fill_done <= 1'b1;
                end
            end
            if (rewind) begin
                slice_ptr <= '0;
                col_ptr <= '0;
            end
        end
    end

    // Returning pixels always go to the buffer that is not shown
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (show_b) begin
                buf_a[wr_idx] <= rd_data;
            end else begin
                buf_b[wr_idx] <= rd_data;
            end
        end
    end

    // Planes 8 to 4 map to bits 4 to 0 of red and blue, green is one bit up
    assign color_plane = plane_num >= 4'(pov_pkg::poker_planes - pov_pkg::color_planes);
    assign color_bit = 3'(plane_num - 4'(pov_pkg::poker_planes - pov_pkg::color_planes));

    always_comb begin
        int row;
        int pos;
        int idx;
        pov_pkg::pixel_t px;
        pov_pkg::led_bits_t bits;
        plane = '0;
        for (int p = 0; p < pov_pkg::num_drivers / 2; p++) begin
            row = p / pov_pkg::pairs_per_row;
            pos = p % pov_pkg::pairs_per_row;
            for (int l = 0; l < pov_pkg::leds_per_driver; l++) begin
                // Rows of LEDs are interleaved across the pairs of one driver row
                idx = (row * pov_pkg::leds_per_driver + l) * pov_pkg::pairs_per_row + pos;
                px = show_b ? buf_b[idx] : buf_a[idx];
                bits.red = px.red[color_bit];
                bits.green = px.green[color_bit + 3'd1];
                bits.blue = px.blue[color_bit];
                // Dark planes stay zero
                if (color_plane) begin
                    // Facing drivers sit at the same spot and show the same pixel
                    plane[2*p][l] = bits;
                    plane[2*p+1][l] = bits;
                end
            end
        end
    end

endmodule

//--- hdl/pov_display_top.sv
`timescale 1ns/1ps

module pov_display_top (
    input  logic clk,
    input  logic nrst,

    // Host loads image slices here
    input  pov_pkg::wb_req_t wb_req,
    output pov_pkg::wb_rsp_t wb_rsp,

    input  logic stream_enable,
    input  logic driver_ready,

    // Plane stream towards the LED drivers
    output pov_pkg::driver_plane_t plane,
    output logic [3:0] plane_num,
    output logic plane_valid
);

    logic [pov_pkg::ram_addr_w-1:0] rd_addr;
    pov_pkg::pixel_t rd_data;
    logic swap;
    logic rewind;
    logic fill_done;

    slice_ram i_slice_ram (
        .clk     (clk),
        .nrst    (nrst),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    framebuffer i_framebuffer (
        .clk       (clk),
        .nrst      (nrst),
        .swap      (swap),
        .rewind    (rewind),
        .plane_num (plane_num),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .fill_done (fill_done),
        .plane     (plane)
    );

    // Sole owner of the buffer swap timing
    column_sequencer i_column_sequencer (
        .clk           (clk),
        .nrst          (nrst),
        .stream_enable (stream_enable),
        .driver_ready  (driver_ready),
        .fill_done     (fill_done),
        .swap          (swap),
        .rewind        (rewind),
        .plane_num     (plane_num),
        .plane_valid   (plane_valid)
    );

endmodule

//--- hdl/slice_ram.sv
`timescale 1ns/1ps

module slice_ram (
    input  logic clk,
    input  logic nrst,

    // Host port, Wishbone classic slave
    input  pov_pkg::wb_req_t wb_req,
    output pov_pkg::wb_rsp_t wb_rsp,

    // Private read port of the framebuffer, one cycle of latency
    input  logic [pov_pkg::ram_addr_w-1:0] rd_addr,
    output pov_pkg::pixel_t rd_data
);

    // The pixel array holds all slices back to back
    pov_pkg::pixel_t mem [pov_pkg::ram_words];

    logic ack;
    logic req_hit;
    pov_pkg::pixel_t wb_dat;

    // A new cycle is taken only while no ack is out, so every transfer gets
    // exactly one single-cycle ack even though the host keeps stb up until
    // it has seen it
    assign req_hit = wb_req.cyc && wb_req.stb && !ack;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack <= 1'b0;
        end else begin
            ack <= req_hit;
        end
    end

    // Host writes and reads are both served in the cycle the request is taken
    always_ff @(posedge clk) begin
        if (req_hit && wb_req.we) begin
            mem[wb_req.adr] <= wb_req.dat;
        end
        if (req_hit && !wb_req.we) begin
            wb_dat <= mem[wb_req.adr];
        end
    end

    // Framebuffer port, no handshake, data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Read data sits in the response register until the next read
    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = wb_dat;

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module pov_display_tb -f verilog.f

# The simulator's own exit status is ignored here, the log decides
./obj_dir/Vpov_display_tb 2>&1 | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

//--- verification/pov_display_properties.sv
`timescale 1ns/1ps

module pov_display_properties (
    input logic clk,
    input logic nrst,
    input pov_pkg::wb_req_t wb_req,
    input pov_pkg::wb_rsp_t wb_rsp,
    input logic driver_ready,
    input pov_pkg::driver_plane_t plane,
    input logic [3:0] plane_num,
    input logic plane_valid
);

    // An ack always answers a request seen in the cycle before
    ack_after_req: assert property (@(posedge clk) disable iff (!nrst)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without a preceding cyc and stb");

    // A stalled plane stays put unless the stream is stopped, which drops plane_valid
    plane_hold: assert property (@(posedge clk) disable iff (!nrst)
        plane_valid && !driver_ready |=> !plane_valid || ($stable(plane) && $stable(plane_num)))
        else $error("plane changed while the driver was not ready");

    no_valid_after_reset: assert property (@(posedge clk) $rose(nrst) |-> !plane_valid)
        else $error("plane_valid high right after reset");

    plane_num_range: assert property (@(posedge clk) disable iff (!nrst) plane_num <= 4'd8)
        else $error("plane_num out of range");

endmodule

bind pov_display_top pov_display_properties i_pov_display_properties (
    .clk          (clk),
    .nrst         (nrst),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .driver_ready (driver_ready),
    .plane        (plane),
    .plane_num    (plane_num),
    .plane_valid  (plane_valid)
);

//--- verification/pov_display_tb.sv
`timescale 1ns/1ps

module pov_display_tb;

    typedef logic [pov_pkg::ram_addr_w-1:0] addr_t;

    logic clk;
    logic nrst;
    pov_pkg::wb_req_t wb_req;
    pov_pkg::wb_rsp_t wb_rsp;
    logic stream_enable;
    logic driver_ready;
    pov_pkg::driver_plane_t plane;
    logic [3:0] plane_num;
    logic plane_valid;

    // Mirror of everything the host has written into the pixel RAM
    pov_pkg::pixel_t shadow [pov_pkg::ram_words];
    logic [31:0] rng_state = 32'd83787;

    pov_display_top i_pov_display_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Budget of 3 cycles per Wishbone transfer and 49 fill plus 12 plane cycles per column,
    // with 40 columns covering priming and the restart, then doubled
    initial begin
        int cycles;
        int limit;
        cycles = 0;
        limit = 2 * (2 * pov_pkg::ram_words * 3 + 40 * (49 + 12) + 100);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run hung waiting for the DUT", limit);
        abort_run();
    end

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pov_pkg::pixel_t exp,
                               input pov_pkg::pixel_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_plane(input string name, input pov_pkg::driver_plane_t exp,
                               input pov_pkg::driver_plane_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_plane_num(input string name, input logic [3:0] exp,
                                   input logic [3:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s expected %0d planes actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // Expected plane n of one column as built from the shadow copy
    function automatic pov_pkg::driver_plane_t model_plane(input int slice, input int col,
                                                           input int n);
        pov_pkg::driver_plane_t pl;
        pov_pkg::pixel_t px;
        int k;
        pl = '0;
        if (n >= pov_pkg::poker_planes - pov_pkg::color_planes) begin
            for (int p = 0; p < pov_pkg::num_drivers / 2; p++) begin
                for (int l = 0; l < pov_pkg::leds_per_driver; l++) begin
                    k = ((p / pov_pkg::pairs_per_row) * pov_pkg::leds_per_driver + l)
                        * pov_pkg::pairs_per_row + p % pov_pkg::pairs_per_row;
                    px = shadow[slice * pov_pkg::image_size + col + pov_pkg::mux_columns * k];
                    pl[2*p][l].red = px.red[n - 4];
                    pl[2*p][l].green = px.green[n - 3];
                    pl[2*p][l].blue = px.blue[n - 4];
                    // Both drivers of a facing pair light the same pixel
                    pl[2*p+1][l] = pl[2*p][l];
                end
            end
        end
        return pl;
    endfunction

    // One Wishbone classic transfer holds the request until ack is seen
    task automatic wb_transfer(input logic we, input int adr, input pov_pkg::pixel_t dat,
                               output pov_pkg::pixel_t rdat);
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we <= we;
        wb_req.adr <= addr_t'(adr);
        wb_req.dat <= dat;
        do @(negedge clk); while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
    endtask

    // Follows accepted planes under random back-pressure from column index first on
    task automatic watch_planes(input string name, input int first, input int planes);
        int seen;
        int in_col;
        int col;
        int n;
        seen = 0;
        in_col = 0;
        while (seen < planes) begin
            @(posedge clk);
            // Ready about three cycles in four
            driver_ready <= (next_random() & 32'd3) != 32'd0;
            @(negedge clk);
            if (plane_valid && driver_ready) begin
                col = first + seen / pov_pkg::poker_planes;
                n = pov_pkg::poker_planes - 1 - seen % pov_pkg::poker_planes;
                // The DUT closes a column with its last plane, and every plane of that
                // column must have been taken exactly once by then
                in_col++;
                if (plane_num == 4'd0) begin
                    check_count(name, pov_pkg::poker_planes, in_col);
                    in_col = 0;
                end
                check_plane_num(name, 4'(n), plane_num);
                check_plane(name, model_plane((col / pov_pkg::mux_columns)
                    % pov_pkg::slices_in_ram, col % pov_pkg::mux_columns, n), plane);
                seen++;
            end
        end
    endtask

    initial begin
        pov_pkg::pixel_t rdat;
        logic [31:0] rnd;
        nrst = 1'b0;
        wb_req = '0;
        stream_enable = 1'b0;
        driver_ready = 1'b0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;

        // Fill the whole RAM, then read every word back
        for (int a = 0; a < pov_pkg::ram_words; a++) begin
            rnd = next_random();
            shadow[a] = rnd[15:0];
            wb_transfer(1'b1, a, shadow[a], rdat);
        end
        for (int a = 0; a < pov_pkg::ram_words; a++) begin
            wb_transfer(1'b0, a, '0, rdat);
            check_pixel("wb_readback", shadow[a], rdat);
        end

        // Two full wraps of all slices, then stop a few planes into slice 0 column 1
        @(posedge clk);
        stream_enable <= 1'b1;
        watch_planes("stream_wraps", 0, 33 * pov_pkg::poker_planes + 4);
        @(posedge clk);
        stream_enable <= 1'b0;
        repeat (60) @(posedge clk);
        stream_enable <= 1'b1;
        // A restart begins again at slice 0 column 0
        watch_planes("stream_restart", 0, 2 * pov_pkg::poker_planes);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- verilog.f
common/pov_pkg.sv
hdl/slice_ram.sv
framebuffer/framebuffer.sv
framebuffer/column_sequencer.sv
hdl/pov_display_top.sv
verification/pov_display_properties.sv
verification/pov_display_tb.sv
